//--- build.f
+incdir+include
src/xdata_pkg.sv
src/xdata_ctrl.sv
src/xmem_unit.sv
src/xalu_unit.sv
src/xmul_unit.sv
src/xdata_eng.sv
verification/xdata_eng_properties.sv
verification/xdata_eng_tb.sv

//--- include/xdata_params.svh
/*
 * data engine geometry
 * word width, memory size, bus size and control field widths
 */
`ifndef XDATA_PARAMS_SVH
`define XDATA_PARAMS_SVH

// datapath word
`define DATA_W 16

// two dual-port memories of 64 words each
`define N_MEM 2
`define MEM_ADDR_W 6

// data bus sources and their select width
`define N_SRC 8
`define SEL_W 3

// host address widths, top bit of the control address picks the control register
`define CTR_ADDR_W 8
`define DATA_ADDR_W 7

// port B write delay
`define DELAY_W 3

// fixed data bus slots
`define SRC_ZERO 0
`define SRC_ONE 1
`define SRC_MEM0A 2
`define SRC_ALU0 6
`define SRC_MUL0 7

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# compile the data engine testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
   -f build.f --top-module xdata_eng_tb --Mdir obj_dir -o xdata_eng_sim &&
./obj_dir/xdata_eng_sim || exit 1

//--- src/xalu_unit.sv
/*
 * ALU unit
 * two operands picked from the data bus, result registered
 */
`timescale 1ns/1ns
`include "xdata_params.svh"

module xalu_unit (
   input  logic                  clk,   // asynchronous reset, active high
   input  logic                  rst,   // clock
   input  xdata_pkg::data_bus_t  bus_in,
   input  xdata_pkg::alu_cfg_t   cfg,
   output xdata_pkg::data_word_t result
);
   import xdata_pkg::*;

   data_word_t op_a;
   data_word_t op_b;
   data_word_t alu_nxt;

   assign op_a = bus_in[cfg.sel_a];
   assign op_b = bus_in[cfg.sel_b];

   always_comb begin
      case (cfg.op)
         ALU_ADD:  alu_nxt = op_a + op_b;
         ALU_SUB:  alu_nxt = op_a - op_b;
         ALU_AND:  alu_nxt = op_a & op_b;
         ALU_OR:   alu_nxt = op_a | op_b;
         ALU_XOR:  alu_nxt = op_a ^ op_b;
         ALU_PASS: alu_nxt = op_a;
         // unused encodings
         default:  alu_nxt = '0;
      endcase
   end

   // one cycle from operands to bus
   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         result <= '0;
      else
         result <= alu_nxt;
   end

endmodule

//--- src/xdata_ctrl.sv
/*
 * data engine control
 * host address decode, run start, configuration shadow,
 * run/idle state and host read-back
 */
`timescale 1ns/1ns
`include "xdata_params.svh"

module xdata_ctrl (
   input  logic                    clk,   // asynchronous reset, active high
   input  logic                    rst,   // clock
   input  logic                    ctr_valid,
   input  logic                    ctr_we,
   input  logic [`CTR_ADDR_W-1:0]  ctr_addr,
   input  xdata_pkg::data_word_t   ctr_data_in,
   input  logic                    data_valid,
   input  logic [`DATA_ADDR_W-1:0] data_addr,
   input  xdata_pkg::data_bus_t    data_bus,
   input  logic [2*`N_MEM-1:0]     mem_done,
   input  xdata_pkg::engine_cfg_t  config_bus,
   output logic [`N_MEM-1:0]       ctr_mem_sel,
   output logic [`N_MEM-1:0]       data_mem_sel,
   output logic                    run_start,
   output xdata_pkg::engine_cfg_t  cfg,
   output xdata_pkg::data_word_t   ctr_data_out,
   output xdata_pkg::data_word_t   data_data_out
);
   import xdata_pkg::*;

   eng_state_e state;
   logic       ctrl_reg_sel;
   logic       run_strobe;
   logic       ctr_rd_pend;
   logic [`DATA_ADDR_W-`MEM_ADDR_W-1:0] ctr_mem_q;
   logic [`DATA_ADDR_W-`MEM_ADDR_W-1:0] data_mem_q;
   data_word_t ctr_rd_word;
   data_word_t ctr_hold;

   // port B slot of memory m, it carries host reads while idle
   function automatic src_sel_t port_b_slot(input int m);
      return src_sel_t'(`SRC_MEM0A + 2*m + 1);
   endfunction

   assign ctrl_reg_sel = ctr_valid & ctr_addr[`CTR_ADDR_W-1];
   assign run_strobe   = ctrl_reg_sel & ctr_we & ctr_data_in[0];

   always_comb begin
      ctr_mem_sel  = '0;
      data_mem_sel = '0;
      for (int j = 0; j < `N_MEM; j++) begin
         if (ctr_valid && !ctr_addr[`CTR_ADDR_W-1] &&
             int'(ctr_addr[`CTR_ADDR_W-2:`MEM_ADDR_W]) == j)
            ctr_mem_sel[j] = 1'b1;
         if (data_valid && int'(data_addr[`DATA_ADDR_W-1:`MEM_ADDR_W]) == j)
            data_mem_sel[j] = 1'b1;
      end
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         state       <= ENG_IDLE;
         run_start   <= 1'b0;
         cfg         <= '0;
         ctr_rd_pend <= 1'b0;
         ctr_mem_q   <= '0;
         data_mem_q  <= '0;
         ctr_hold    <= '0;
      end else begin
         run_start <= run_strobe;
         if (run_strobe)
            cfg <= config_bus;
         case (state)
            ENG_IDLE: if (run_strobe) state <= ENG_RUN;
            // done levels only fall on run_start, so skip that cycle
            ENG_RUN:  if (!run_start && &mem_done) state <= ENG_IDLE;
            default:  state <= ENG_IDLE;
         endcase
         ctr_rd_pend <= |ctr_mem_sel && !ctr_we;
         if (|ctr_mem_sel)
            ctr_mem_q <= ctr_addr[`CTR_ADDR_W-2:`MEM_ADDR_W];
         if (data_valid)
            data_mem_q <= data_addr[`DATA_ADDR_W-1:`MEM_ADDR_W];
         if (ctr_rd_pend)
            ctr_hold <= ctr_rd_word;
      end
   end

   assign ctr_rd_word   = data_bus[port_b_slot(int'(ctr_mem_q))];
   assign data_data_out = data_bus[port_b_slot(int'(data_mem_q))];

   // status is combinational, memory words held until the next read
   always_comb begin
      if (ctrl_reg_sel)
         ctr_data_out = data_word_t'(state == ENG_IDLE);
      else if (ctr_rd_pend)
         ctr_data_out = ctr_rd_word;
      else
         ctr_data_out = ctr_hold;
   end

endmodule

//--- src/xdata_eng.sv
/*
 * data engine top
 * builds the shared data bus and ties the control block
 * to two memories, the ALU and the multiplier
 */
`timescale 1ns/1ns
`include "xdata_params.svh"

module xdata_eng (
   input  logic                    clk,   // asynchronous reset, active high
   input  logic                    rst,   // clock
   input  logic                    ctr_valid,
   input  logic                    ctr_we,
   input  logic [`CTR_ADDR_W-1:0]  ctr_addr,
   input  xdata_pkg::data_word_t   ctr_data_in,
   output xdata_pkg::data_word_t   ctr_data_out,
   input  logic                    data_valid,
   input  logic                    data_we,
   input  logic [`DATA_ADDR_W-1:0] data_addr,
   input  xdata_pkg::data_word_t   data_data_in,
   output xdata_pkg::data_word_t   data_data_out,
   input  xdata_pkg::engine_cfg_t  config_bus
);
   import xdata_pkg::*;

   data_bus_t           data_bus;
   engine_cfg_t         cfg;
   logic [`N_MEM-1:0]   ctr_mem_sel;
   logic [`N_MEM-1:0]   data_mem_sel;
   logic [2*`N_MEM-1:0] mem_done;
   logic                run_start;
   data_word_t          mem0_a_out;
   data_word_t          mem0_b_out;
   data_word_t          mem1_a_out;
   data_word_t          mem1_b_out;
   data_word_t          alu0_out;
   data_word_t          mul0_out;

   assign data_bus[`SRC_ZERO]    = '0;
   assign data_bus[`SRC_ONE]     = data_word_t'(1);
   assign data_bus[`SRC_MEM0A]   = mem0_a_out;
   assign data_bus[`SRC_MEM0A+1] = mem0_b_out;
   assign data_bus[`SRC_MEM0A+2] = mem1_a_out;
   assign data_bus[`SRC_MEM0A+3] = mem1_b_out;
   assign data_bus[`SRC_ALU0]    = alu0_out;
   assign data_bus[`SRC_MUL0]    = mul0_out;

   xdata_ctrl ctrl0 (
      .clk(clk), .rst(rst),
      .ctr_valid(ctr_valid), .ctr_we(ctr_we), .ctr_addr(ctr_addr),
      .ctr_data_in(ctr_data_in), .data_valid(data_valid), .data_addr(data_addr),
      .data_bus(data_bus), .mem_done(mem_done), .config_bus(config_bus),
      .ctr_mem_sel(ctr_mem_sel), .data_mem_sel(data_mem_sel),
      .run_start(run_start), .cfg(cfg),
      .ctr_data_out(ctr_data_out), .data_data_out(data_data_out)
   );

   xmem_unit mem0 (
      .clk(clk), .rst(rst), .run_start(run_start),
      .host_sel_ctr(ctr_mem_sel[0]), .host_sel_data(data_mem_sel[0]),
      .ctr_we(ctr_we), .data_we(data_we),
      .ctr_addr_w(ctr_addr[`MEM_ADDR_W-1:0]), .data_addr_w(data_addr[`MEM_ADDR_W-1:0]),
      .ctr_wdata(ctr_data_in), .data_wdata(data_data_in),
      .cfg_a(cfg.mem0_a), .cfg_b(cfg.mem0_b), .bus_in(data_bus),
      .out_a(mem0_a_out), .out_b(mem0_b_out),
      .done_a(mem_done[0]), .done_b(mem_done[1])
   );

   xmem_unit mem1 (
      .clk(clk), .rst(rst), .run_start(run_start),
      .host_sel_ctr(ctr_mem_sel[1]), .host_sel_data(data_mem_sel[1]),
      .ctr_we(ctr_we), .data_we(data_we),
      .ctr_addr_w(ctr_addr[`MEM_ADDR_W-1:0]), .data_addr_w(data_addr[`MEM_ADDR_W-1:0]),
      .ctr_wdata(ctr_data_in), .data_wdata(data_data_in),
      .cfg_a(cfg.mem1_a), .cfg_b(cfg.mem1_b), .bus_in(data_bus),
      .out_a(mem1_a_out), .out_b(mem1_b_out),
      .done_a(mem_done[2]), .done_b(mem_done[3])
   );

   xalu_unit alu0 (
      .clk(clk), .rst(rst), .bus_in(data_bus), .cfg(cfg.alu0), .result(alu0_out)
   );

   xmul_unit mul0 (
      .clk(clk), .rst(rst), .bus_in(data_bus), .cfg(cfg.mul0), .result(mul0_out)
   );

endmodule

//--- src/xdata_pkg.sv
/*
 * data engine types
 * bus words, data bus layout, unit configuration and control states
 */
`include "xdata_params.svh"

package xdata_pkg;

   typedef logic [`DATA_W-1:0] data_word_t;
   typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
   typedef logic [`SEL_W-1:0] src_sel_t;
   // word count, 0 up to a full memory
   typedef logic [`MEM_ADDR_W:0] mem_cnt_t;
   typedef logic [`DELAY_W-1:0] delay_t;

   // slots: 0, 1, mem0 A/B, mem1 A/B, alu0, mul0
   typedef data_word_t [`N_SRC-1:0] data_bus_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS
   } alu_op_e;

   typedef struct packed {
      logic      enable;
      src_sel_t  sel;
      mem_addr_t start;
      mem_cnt_t  count;
      delay_t    delay;
   } mem_port_cfg_t;

   typedef struct packed {
      src_sel_t sel_a;
      src_sel_t sel_b;
      alu_op_e  op;
   } alu_cfg_t;

   typedef struct packed {
      src_sel_t sel_a;
      src_sel_t sel_b;
   } mul_cfg_t;

   typedef struct packed {
      mem_port_cfg_t mem0_a;
      mem_port_cfg_t mem0_b;
      mem_port_cfg_t mem1_a;
      mem_port_cfg_t mem1_b;
      alu_cfg_t      alu0;
      mul_cfg_t      mul0;
   } engine_cfg_t;

   typedef enum logic {
      ENG_IDLE,
      ENG_RUN
   } eng_state_e;

endpackage

//--- src/xmem_unit.sv
/*
 * dual-port data memory
 * port A streams words onto the bus, port B writes a bus source
 * after a delay and serves host accesses when idle
 */
`timescale 1ns/1ns
`include "xdata_params.svh"

module xmem_unit (
   input  logic                     clk,   // asynchronous reset, active high
   input  logic                     rst,   // clock
   input  logic                     run_start,
   input  logic                     host_sel_ctr,
   input  logic                     host_sel_data,
   input  logic                     ctr_we,
   input  logic                     data_we,
   input  xdata_pkg::mem_addr_t     ctr_addr_w,
   input  xdata_pkg::mem_addr_t     data_addr_w,
   input  xdata_pkg::data_word_t    ctr_wdata,
   input  xdata_pkg::data_word_t    data_wdata,
   input  xdata_pkg::mem_port_cfg_t cfg_a,
   input  xdata_pkg::mem_port_cfg_t cfg_b,
   input  xdata_pkg::data_bus_t     bus_in,
   output xdata_pkg::data_word_t    out_a,
   output xdata_pkg::data_word_t    out_b,
   output logic                     done_a,
   output logic                     done_b
);
   import xdata_pkg::*;

   data_word_t mem [2**`MEM_ADDR_W];

   mem_addr_t a_addr;
   mem_cnt_t  a_left;
   mem_addr_t rd_addr_a;
   logic      stream_a;

   mem_addr_t b_addr;
   mem_cnt_t  b_left;
   delay_t    b_wait;
   logic      b_write;
   mem_addr_t addr_b;

   // first word is read on the run_start edge itself
   assign stream_a  = (run_start & cfg_a.enable) | ~done_a;
   assign rd_addr_a = run_start ? cfg_a.start : a_addr;

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         a_addr <= '0;
         a_left <= '0;
         done_a <= 1'b1;
      end else begin
         if (stream_a)
            a_addr <= rd_addr_a + 1'b1;
         if (run_start && cfg_a.enable) begin
            a_left <= cfg_a.count;
            done_a <= 1'b0;
         end else if (!done_a) begin
            if (a_left <= 1) begin
               a_left <= '0;
               done_a <= 1'b1;
            end else begin
               a_left <= a_left - 1'b1;
            end
         end
      end
   end

   // writes start delay cycles after run_start, delay 0 acts as 1
   assign b_write = ~done_b & (b_wait <= 1) & (b_left != 0);
   assign addr_b  = !done_b ? b_addr : (host_sel_ctr ? ctr_addr_w : data_addr_w);

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         b_addr <= '0;
         b_left <= '0;
         b_wait <= '0;
         done_b <= 1'b1;
      end else if (run_start && cfg_b.enable) begin
         b_addr <= cfg_b.start;
         b_left <= cfg_b.count;
         b_wait <= cfg_b.delay;
         done_b <= 1'b0;
      end else if (!done_b) begin
         if (b_wait > 1) begin
            b_wait <= b_wait - 1'b1;
         end else if (b_left != 0) begin
            b_addr <= b_addr + 1'b1;
            b_left <= b_left - 1'b1;
         end else begin
            done_b <= 1'b1;
         end
      end
   end

   // engine writes win over host writes
   always_ff @(posedge rst) begin
      if (b_write)
         mem[b_addr] <= bus_in[cfg_b.sel];
      else if (host_sel_ctr && ctr_we)
         mem[ctr_addr_w] <= ctr_wdata;
      else if (host_sel_data && data_we)
         mem[data_addr_w] <= data_wdata;
   end

   always_ff @(posedge rst) begin
      if (stream_a)
         out_a <= mem[rd_addr_a];
      out_b <= mem[addr_b];
   end

endmodule

//--- src/xmul_unit.sv
/*
 * multiplier unit
 * registered low word of the product of two bus operands
 */
`timescale 1ns/1ns
`include "xdata_params.svh"

module xmul_unit (
   input  logic                  clk,   // asynchronous reset, active high
   input  logic                  rst,   // clock
   input  xdata_pkg::data_bus_t  bus_in,
   input  xdata_pkg::mul_cfg_t   cfg,
   output xdata_pkg::data_word_t result
);
   import xdata_pkg::*;

   data_word_t op_a;
   data_word_t op_b;
   data_word_t prod_lo;

   assign op_a = bus_in[cfg.sel_a];
   assign op_b = bus_in[cfg.sel_b];

   // word-sized context keeps only the low half
   assign prod_lo = op_a * op_b;

   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         result <= '0;
      else
         result <= prod_lo;
   end

endmodule

//--- verification/xdata_eng_properties.sv
/*
 * control timing assertions for the data engine
 * run start pulse and return to idle
 */
`timescale 1ns/1ns
`include "xdata_params.svh"

module xdata_eng_properties (
   input logic                   clk,   // asynchronous reset, active high
   input logic                   rst,   // clock
   input logic                   ctr_valid,
   input logic                   ctr_we,
   input logic [`CTR_ADDR_W-1:0] ctr_addr,
   input xdata_pkg::data_word_t  ctr_data_in,
   input logic                   run_start,
   input logic [2*`N_MEM-1:0]    mem_done,
   input xdata_pkg::eng_state_e  state
);
   import xdata_pkg::*;

   run_start_pulse: assert property (@(posedge rst) disable iff (clk)
      run_start |=> !run_start)
      else $error("run_start held for more than one cycle");

   // start write to the control register one cycle earlier
   run_start_cause: assert property (@(posedge rst) disable iff (clk)
      run_start |-> $past(ctr_valid && ctr_we && ctr_addr[`CTR_ADDR_W-1] && ctr_data_in[0]))
      else $error("run_start without a start write");

   run_exit: assert property (@(posedge rst) disable iff (clk)
      (state == ENG_RUN) |=> (state == ENG_RUN) || $past(&mem_done))
      else $error("engine left run with a port still busy");

endmodule

bind xdata_ctrl xdata_eng_properties props0 (
   .clk(clk), .rst(rst),
   .ctr_valid(ctr_valid), .ctr_we(ctr_we), .ctr_addr(ctr_addr),
   .ctr_data_in(ctr_data_in), .run_start(run_start),
   .mem_done(mem_done), .state(state)
);

//--- verification/xdata_eng_tb.sv
/*
 * data engine testbench
 * replays the command trace on the host interfaces and checks
 * read-back and status words against the values in the trace
 */
`timescale 1ns/1ns
`include "xdata_params.svh"

module xdata_eng_tb;
   import xdata_pkg::*;

   localparam logic [`CTR_ADDR_W-1:0] ctrl_reg_addr = {1'b1, {(`CTR_ADDR_W-1){1'b0}}};
   localparam int max_polls = 500;

   logic                    clk;   // asynchronous reset, active high
   logic                    rst;   // clock
   logic                    ctr_valid;
   logic                    ctr_we;
   logic [`CTR_ADDR_W-1:0]  ctr_addr;
   data_word_t              ctr_data_in;
   data_word_t              ctr_data_out;
   logic                    data_valid;
   logic                    data_we;
   logic [`DATA_ADDR_W-1:0] data_addr;
   data_word_t              data_data_in;
   data_word_t              data_data_out;
   engine_cfg_t             config_bus;

   int    checks;
   int    fd;
   string test_name;

   xdata_eng dut0 (
      .clk(clk), .rst(rst),
      .ctr_valid(ctr_valid), .ctr_we(ctr_we), .ctr_addr(ctr_addr),
      .ctr_data_in(ctr_data_in), .ctr_data_out(ctr_data_out),
      .data_valid(data_valid), .data_we(data_we), .data_addr(data_addr),
      .data_data_in(data_data_in), .data_data_out(data_data_out),
      .config_bus(config_bus)
   );

   initial begin
      rst = 1'b0;
      forever #20 rst = ~rst;
   end

   task automatic check_value(input string name, input data_word_t expected,
                              input data_word_t actual);
      checks++;
      if (actual !== expected) begin
         $display("Fail %s expected %h actual %h", name, expected, actual);
         $display("TEST FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // strobes low and everything else random
   task automatic idle_inputs();
      logic [31:0] noise_a;
      logic [31:0] noise_b;
      noise_a = $urandom;
      noise_b = $urandom;
      ctr_valid    <= 1'b0;
      data_valid   <= 1'b0;
      ctr_data_in  <= noise_a[`DATA_W-1:0];
      data_data_in <= noise_a[31 -: `DATA_W];
      ctr_addr     <= noise_b[`CTR_ADDR_W-1:0];
      data_addr    <= noise_b[8 +: `DATA_ADDR_W];
      ctr_we       <= noise_b[16];
      data_we      <= noise_b[17];
   endtask

   task automatic write_word(input logic iface, input logic [6:0] addr, input data_word_t word);
      @(posedge rst);
      if (iface) begin
         ctr_valid   <= 1'b1;
         ctr_we      <= 1'b1;
         ctr_addr    <= {1'b0, addr};
         ctr_data_in <= word;
      end else begin
         data_valid   <= 1'b1;
         data_we      <= 1'b1;
         data_addr    <= addr;
         data_data_in <= word;
      end
      @(posedge rst);
      idle_inputs();
   endtask

   // n words from addr with base plus step per word
   task automatic fill_words(input logic [6:0] addr, input logic [6:0] n,
                             input data_word_t base, input data_word_t step);
      logic [6:0] a;
      data_word_t w;
      a = addr;
      w = base;
      for (int k = 0; k < int'(n); k++) begin
         write_word(1'b0, a, w);
         a = a + 1'b1;
         w = w + step;
      end
   endtask

   task automatic read_expect(input logic iface, input logic [6:0] addr,
                              input data_word_t expected);
      data_word_t actual;
      @(posedge rst);
      if (iface) begin
         ctr_valid <= 1'b1;
         ctr_we    <= 1'b0;
         ctr_addr  <= {1'b0, addr};
      end else begin
         data_valid <= 1'b1;
         data_we    <= 1'b0;
         data_addr  <= addr;
      end
      @(posedge rst);
      idle_inputs();
      // word is registered one cycle after the strobe
      @(negedge rst);
      actual = iface ? ctr_data_out : data_data_out;
      check_value($sformatf("%s read %02h", test_name, addr), expected, actual);
      // control read-back stays put until the next memory read
      if (iface) begin
         @(negedge rst);
         check_value($sformatf("%s hold %02h", test_name, addr), expected, ctr_data_out);
      end
   endtask

   task automatic read_status(output logic done);
      @(posedge rst);
      ctr_valid <= 1'b1;
      ctr_we    <= 1'b0;
      ctr_addr  <= ctrl_reg_addr;
      @(negedge rst);
      done = ctr_data_out[0];
      @(posedge rst);
      idle_inputs();
   endtask

   task automatic expect_status(input logic expected);
      logic done;
      read_status(done);
      check_value($sformatf("%s status", test_name), data_word_t'(expected),
                  data_word_t'(done));
   endtask

   task automatic wait_done();
      int   polls;
      logic done;
      polls = 0;
      done  = 1'b0;
      while (!done) begin
         if (polls == max_polls) begin
            $display("TEST FAIL");
            $fatal(1, "engine still busy after %0d status polls in %s", max_polls, test_name);
         end else begin
            read_status(done);
            polls++;
         end
      end
   endtask

   task automatic run_engine();
      @(posedge rst);
      ctr_valid   <= 1'b1;
      ctr_we      <= 1'b1;
      ctr_addr    <= ctrl_reg_addr;
      ctr_data_in <= data_word_t'(1);
      @(posedge rst);
      idle_inputs();
   endtask

   task automatic set_port(input logic [1:0] p, input logic en, input src_sel_t sel,
                           input mem_addr_t start, input mem_cnt_t count, input delay_t delay);
      mem_port_cfg_t pc;
      pc.enable = en;
      pc.sel    = sel;
      pc.start  = start;
      pc.count  = count;
      pc.delay  = delay;
      @(posedge rst);
      case (p)
         2'd0:    config_bus.mem0_a <= pc;
         2'd1:    config_bus.mem0_b <= pc;
         2'd2:    config_bus.mem1_a <= pc;
         default: config_bus.mem1_b <= pc;
      endcase
   endtask

   task automatic set_alu(input src_sel_t sa, input src_sel_t sb, input logic [2:0] op);
      @(posedge rst);
      config_bus.alu0.sel_a <= sa;
      config_bus.alu0.sel_b <= sb;
      config_bus.alu0.op    <= alu_op_e'(op);
   endtask

   task automatic set_mul(input src_sel_t sa, input src_sel_t sb);
      @(posedge rst);
      config_bus.mul0.sel_a <= sa;
      config_bus.mul0.sel_b <= sb;
   endtask

   task automatic clear_config();
      @(posedge rst);
      config_bus <= '0;
   endtask

   task automatic scramble_config();
      logic [95:0] noise;
      noise = {$urandom, $urandom, $urandom};
      @(posedge rst);
      config_bus <= noise[$bits(engine_cfg_t)-1:0];
   endtask

   function automatic string trim_name(input string s);
      int first;
      int last;
      first = 0;
      last  = s.len() - 1;
      while (first <= last && s.getc(first) == " ")
         first++;
      while (last >= first && (s.getc(last) == "\n" || s.getc(last) == "\r" ||
                               s.getc(last) == " "))
         last--;
      return s.substr(first, last);
   endfunction

   task automatic replay_trace(input int fd_in);
      string       line;
      string       args;
      byte         cmd;
      int          line_no;
      logic [31:0] f0;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      logic [31:0] f5;
      line_no = 0;
      while ($fgets(line, fd_in) != 0) begin
         line_no++;
         cmd  = line.getc(0);
         args = line.substr(1, line.len() - 1);
         f0 = '0;
         f1 = '0;
         f2 = '0;
         f3 = '0;
         f4 = '0;
         f5 = '0;
         void'($sscanf(args, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5));
         case (cmd)
            "#", " ", "\n", "\r": ;
            "N": test_name = trim_name(args);
            "W": write_word(f0[0], f1[6:0], f2[15:0]);
            "F": fill_words(f0[6:0], f1[6:0], f2[15:0], f3[15:0]);
            "R": read_expect(f0[0], f1[6:0], f2[15:0]);
            "Q": expect_status(f0[0]);
            "P": set_port(f0[1:0], f1[0], f2[2:0], f3[5:0], f4[6:0], f5[2:0]);
            "A": set_alu(f0[2:0], f1[2:0], f2[2:0]);
            "M": set_mul(f0[2:0], f1[2:0]);
            "Z": clear_config();
            "X": scramble_config();
            "G": run_engine();
            "D": wait_done();
            default: begin
               $display("TEST FAIL");
               $fatal(1, "unknown command on trace line %0d", line_no);
            end
         endcase
      end
   endtask

   initial begin
      void'($urandom(34052));
      checks       = 0;
      test_name    = "reset";
      clk          = 1'b1;
      ctr_valid    = 1'b0;
      ctr_we       = 1'b0;
      ctr_addr     = '0;
      ctr_data_in  = '0;
      data_valid   = 1'b0;
      data_we      = 1'b0;
      data_addr    = '0;
      data_data_in = '0;
      config_bus   = '0;
      repeat (5) @(posedge rst);
      clk <= 1'b0;
      fd = $fopen("verification/xdata_eng_trace.txt", "r");
      if (fd == 0) begin
         $display("TEST FAIL");
         $fatal(1, "trace file could not be opened");
      end else begin
         replay_trace(fd);
         $fclose(fd);
         if (checks > 0) begin
            $display("TEST PASS");
            $finish;
         end else begin
            $display("TEST FAIL");
            $fatal(1, "trace held no checks");
         end
      end
   end

endmodule

//--- verification/xdata_eng_trace.txt
# command letter, then hex fields; W/R iface(0 data, 1 ctrl) addr(bit 6 = mem1) word
# F addr n base step | P port en sel start count delay | A sa sb op | M sa sb | Q done | N name
N host_data
W 0 3f 5a5a
W 0 7f a5c3
R 0 3f 5a5a
R 0 7f a5c3
N host_ctrl
Q 1
W 1 45 0f0f
R 1 45 0f0f
R 1 7f a5c3
N vector_add
F 00 20 f000 0321
F 40 08 1234 0111
Z
P 0 1 0 00 08 0
P 2 1 0 00 08 0
P 3 1 6 20 08 2
A 2 4 0
G
D
R 0 60 0234
R 0 61 0666
R 0 62 0a98
R 0 63 0eca
R 0 64 12fc
R 0 65 172e
R 0 66 1b60
R 0 67 1f92
N multiply
Z
P 0 1 0 00 04 0
P 1 1 7 30 04 2
M 2 1
G
D
R 1 30 f000
R 1 31 f321
R 1 32 f642
R 1 33 f963
N alu_ops
Z
P 0 1 0 06 01 0
P 2 1 0 06 01 0
P 3 1 6 28 01 2
A 2 4 1
G
D
R 0 68 ea2c
A 2 4 2
G
D
R 0 68 0082
A 2 4 4
G
D
R 0 68 1a5c
A 2 4 5
G
D
R 0 68 02c6
N shadow_config
Z
P 0 1 0 00 20 0
P 3 1 6 20 20 2
A 2 0 5
G
Q 0
X
D
R 0 60 f000
R 0 63 f963
R 1 67 05e7
